// File: design/arith_unit_if.sv
`timescale 1ns/1ps
`default_nettype none

interface arith_unit_if;
	import muldiv_types_pkg::*;

	logic valid; // Request held until ready
	word_t operand_a; // Magnitudes, signs already stripped
	word_t operand_b;
	logic ready; // One cycle pulse
	dword_t result; // Valid with ready

	// Control side
	modport requester (output valid, output operand_a, output operand_b,
		input ready, input result);

	// Datapath side
	modport unit (input valid, input operand_a, input operand_b,
		output ready, output result);

endinterface

`default_nettype wire

// File: design/muldiv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_ctrl (
	input logic clk,
	input logic rst_n,
	input logic valid,
	input muldiv_op_pkg::muldiv_op_t op,
	input muldiv_types_pkg::word_t operand_a,
	input muldiv_types_pkg::word_t operand_b,
	output logic ready,
	output muldiv_types_pkg::word_t result,
	arith_unit_if.requester mul_bus,
	arith_unit_if.requester div_bus
);
	import muldiv_types_pkg::*;
	import muldiv_op_pkg::*;

	ctrl_state_t state;

	muldiv_op_t op_q; // Operation in flight
	logic negate_q; // Result sign fixup
	word_t a_q, b_q; // Operand magnitudes

	logic a_signed, b_signed;
	logic a_neg, b_neg;
	word_t abs_a, abs_b;
	logic negate;
	logic is_div;

	dword_t mul_fix;
	word_t quo, rem;
	word_t fixed;

	// Request decode, evaluated while idle
	always_comb begin
		a_signed = (op == OP_MULH) || (op == OP_MULHSU) || (op == OP_DIV) || (op == OP_REM);
		b_signed = (op == OP_MULH) || (op == OP_DIV) || (op == OP_REM);
		a_neg = a_signed && operand_a[XLEN-1];
		b_neg = b_signed && operand_b[XLEN-1];
		abs_a = a_neg ? -operand_a : operand_a;
		abs_b = b_neg ? -operand_b : operand_b;
		is_div = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
		case (op)
			OP_DIV, OP_DIVU: negate = (a_neg ^ b_neg) && (operand_b != '0); // Div by zero stays all ones
			OP_REM, OP_REMU: negate = a_neg; // Remainder takes the dividend sign
			default: negate = a_neg ^ b_neg;
		endcase
	end

	// Both datapaths see the same magnitudes
	assign mul_bus.operand_a = a_q;
	assign mul_bus.operand_b = b_q;
	assign div_bus.operand_a = a_q;
	assign div_bus.operand_b = b_q;

	// Sign fixup and word selection on the unit result
	always_comb begin
		mul_fix = negate_q ? -mul_bus.result : mul_bus.result; // Full width before selecting
		quo = div_bus.result[XLEN-1:0];
		rem = div_bus.result[2*XLEN-1:XLEN];
		case (op_q)
			OP_MUL: fixed = mul_fix[XLEN-1:0];
			OP_MULH, OP_MULHSU, OP_MULHU: fixed = mul_fix[2*XLEN-1:XLEN];
			OP_DIV, OP_DIVU: fixed = negate_q ? -quo : quo;
			default: fixed = negate_q ? -rem : rem;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= CTRL_IDLE;
			ready <= 1'b0;
			mul_bus.valid <= 1'b0;
			div_bus.valid <= 1'b0;
		end else begin
			case (state)
				CTRL_IDLE: begin
					if (valid && !ready) begin
						op_q <= op;
						negate_q <= negate;
						a_q <= abs_a;
						b_q <= abs_b;
						if (is_div) begin
							div_bus.valid <= 1'b1;
							state <= CTRL_DIV;
						end else begin
							mul_bus.valid <= 1'b1;
							state <= CTRL_MUL;
						end
					end
				end
				CTRL_MUL: begin
					if (mul_bus.ready) begin
						mul_bus.valid <= 1'b0;
						result <= fixed;
						ready <= 1'b1;
						state <= CTRL_DONE;
					end
				end
				CTRL_DIV: begin
					if (div_bus.ready) begin
						div_bus.valid <= 1'b0;
						result <= fixed; // MIN / -1 needs no special case
						ready <= 1'b1;
						state <= CTRL_DONE;
					end
				end
				CTRL_DONE: begin
					ready <= 1'b0; // Result holds until next completion
					state <= CTRL_IDLE;
				end
				default: state <= CTRL_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/muldiv_divider.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_divider (
	input logic clk,
	input logic rst_n,
	arith_unit_if.unit bus
);
	import muldiv_types_pkg::*;

	typedef enum logic {
		DIV_IDLE,
		DIV_RUN
	} div_state_t;

	div_state_t state;
	step_t step; // Iterations done so far

	word_t rem; // Partial remainder
	word_t quo; // Dividend shifts out the top, quotient bits in at the bottom
	word_t divisor;

	logic [XLEN:0] shifted; // Remainder with the next dividend bit
	logic [XLEN:0] trial; // Extra bit is the borrow

	always_comb begin
		shifted = {rem, quo[XLEN-1]};
		trial = shifted - {1'b0, divisor};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= DIV_IDLE;
			step <= '0;
			bus.ready <= 1'b0;
		end else begin
			bus.ready <= 1'b0;
			case (state)
				DIV_IDLE: begin
					if (bus.valid && !bus.ready) begin
						rem <= '0;
						quo <= bus.operand_a;
						divisor <= bus.operand_b;
						step <= '0;
						state <= DIV_RUN;
					end
				end
				DIV_RUN: begin
					if (step == step_t'(DIV_STEPS)) begin
						bus.result <= {rem, quo}; // Remainder high, quotient low
						bus.ready <= 1'b1;
						state <= DIV_IDLE;
					end else begin
						step <= step + step_t'(1);
						if (!trial[XLEN]) begin // Divisor fits, keep the difference
							rem <= trial[XLEN-1:0];
							quo <= {quo[XLEN-2:0], 1'b1};
						end else begin // Restore
							rem <= shifted[XLEN-1:0];
							quo <= {quo[XLEN-2:0], 1'b0};
						end
					end
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	// Zero divisor never borrows, so quotient ends all ones and remainder equals dividend

endmodule

`default_nettype wire

// File: design/muldiv_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_multiplier (
	input logic clk,
	input logic rst_n,
	arith_unit_if.unit bus
);
	import muldiv_types_pkg::*;

	// a * b = a_lo*b_lo + (a_hi*b_lo + a_lo*b_hi) << 16 + a_hi*b_hi << 32
	typedef enum logic {
		MUL_IDLE,
		MUL_RUN
	} mul_state_t;

	mul_state_t state;
	logic [2:0] cycle; // Partial product index, then two drain cycles

	half_t a_lo, a_hi; // Operand halves
	half_t b_lo, b_hi;

	dword_t accumulator; // Running sum
	dword_t intermediate; // Shifted partial product of the last cycle

	half_t mult_in0, mult_in1; // Shared 16x16 multiplier inputs
	word_t mult_out;
	logic [5:0] shift_count; // 0, 16 or 32

	always_comb begin
		mult_in0 = b_lo; // Default pair, unused outside cycles 0..3
		mult_in1 = a_lo;
		shift_count = 6'd0;
		case (cycle)
			3'd0: begin
				mult_in0 = b_lo;
				mult_in1 = a_lo;
			end
			3'd1: begin
				mult_in0 = b_lo;
				mult_in1 = a_hi;
				shift_count = 6'd16;
			end
			3'd2: begin
				mult_in0 = b_hi;
				mult_in1 = a_lo;
				shift_count = 6'd16;
			end
			3'd3: begin
				mult_in0 = b_hi;
				mult_in1 = a_hi;
				shift_count = 6'd32;
			end
			default: ;
		endcase
	end

	assign mult_out = word_t'(mult_in0) * word_t'(mult_in1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= MUL_IDLE;
			cycle <= 3'd0;
			bus.ready <= 1'b0;
		end else begin
			bus.ready <= 1'b0; // Pulse only
			case (state)
				MUL_IDLE: begin
					if (bus.valid && !bus.ready) begin
						a_lo <= bus.operand_a[HALF-1:0];
						a_hi <= bus.operand_a[XLEN-1:HALF];
						b_lo <= bus.operand_b[HALF-1:0];
						b_hi <= bus.operand_b[XLEN-1:HALF];
						accumulator <= '0;
						intermediate <= '0;
						cycle <= 3'd0;
						state <= MUL_RUN;
					end
				end
				MUL_RUN: begin
					accumulator <= accumulator + intermediate; // One cycle behind the multiply
					cycle <= cycle + 3'd1;
					case (cycle)
						3'd0, 3'd1, 3'd2, 3'd3:
							intermediate <= dword_t'(mult_out) << shift_count;
						3'd4: intermediate <= '0; // Last partial product lands in the sum
						default: begin
							bus.result <= accumulator; // Final product
							bus.ready <= 1'b1;
							state <= MUL_IDLE;
						end
					endcase
				end
				default: state <= MUL_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/muldiv_op_pkg.sv
`default_nettype none

package muldiv_op_pkg;

	// RISC-V funct3 encoding of the M extension
	typedef enum logic [2:0] {
		OP_MUL    = 3'b000, // Low word of the product
		OP_MULH   = 3'b001, // High word, signed x signed
		OP_MULHSU = 3'b010, // High word, signed x unsigned
		OP_MULHU  = 3'b011, // High word, unsigned x unsigned
		OP_DIV    = 3'b100,
		OP_DIVU   = 3'b101,
		OP_REM    = 3'b110,
		OP_REMU   = 3'b111
	} muldiv_op_t;

	// Control FSM of the unit
	typedef enum logic [1:0] {
		CTRL_IDLE = 2'd0, // Waiting for a request
		CTRL_MUL  = 2'd1, // Multiplier busy
		CTRL_DIV  = 2'd2, // Divider busy
		CTRL_DONE = 2'd3  // Ready pulse
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: design/muldiv_top.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_top (
	input logic clk,
	input logic rst_n,
	input logic valid, // Held with op and operands until ready
	input muldiv_op_pkg::muldiv_op_t op,
	input muldiv_types_pkg::word_t operand_a,
	input muldiv_types_pkg::word_t operand_b,
	output logic ready, // One cycle completion pulse
	output muldiv_types_pkg::word_t result
);

	arith_unit_if mul_bus (); // Control to multiplier
	arith_unit_if div_bus (); // Control to divider

	muldiv_ctrl i_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.valid     (valid),
		.op        (op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ready     (ready),
		.result    (result),
		.mul_bus   (mul_bus.requester),
		.div_bus   (div_bus.requester)
	);

	// Seven cycles from valid to ready
	muldiv_multiplier i_mul (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (mul_bus.unit)
	);

	// DIV_STEPS + 2 cycles from valid to ready
	muldiv_divider i_div (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (div_bus.unit)
	);

endmodule

`default_nettype wire

// File: design/muldiv_types_pkg.sv
`default_nettype none

package muldiv_types_pkg;

	localparam int XLEN = 32; // RV32 operand width
	localparam int HALF = XLEN / 2; // Operand half inside the multiplier
	localparam int DIV_STEPS = XLEN; // One quotient bit per iteration
	localparam int STEP_W = $clog2(DIV_STEPS + 1); // Counter reaches DIV_STEPS itself

	typedef logic [XLEN-1:0] word_t; // Operands and results
	typedef logic [2*XLEN-1:0] dword_t; // Full product, or {remainder, quotient}
	typedef logic [HALF-1:0] half_t; // Multiplier operand halves
	typedef logic [STEP_W-1:0] step_t; // Divider iteration count

endpackage

`default_nettype wire

// File: filelist.f
design/muldiv_types_pkg.sv
design/muldiv_op_pkg.sv
design/arith_unit_if.sv
design/muldiv_multiplier.sv
design/muldiv_divider.sv
design/muldiv_ctrl.sv
design/muldiv_top.sv
tests/muldiv_checker.sv
tests/muldiv_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module muldiv_tb -f filelist.f -o muldiv_sim \
	&& ./obj_dir/muldiv_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& exit 0 || exit 1

// File: tests/muldiv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_checker (
	input logic clk,
	input logic rst_n,
	input logic valid,
	input muldiv_op_pkg::muldiv_op_t op,
	input muldiv_types_pkg::word_t operand_a,
	input muldiv_types_pkg::word_t operand_b,
	input logic ready,
	input muldiv_types_pkg::word_t result,
	output int error_count,
	output int check_count
);
	import muldiv_types_pkg::*;
	import muldiv_op_pkg::*;

	int errors = 0;
	int checks = 0;
	logic pending = 1'b0; // Accepted, waiting for ready
	muldiv_op_t op_q;
	word_t a_q, b_q;

	assign error_count = errors;
	assign check_count = checks;

	// RISC-V M rules on 64-bit arithmetic
	function automatic word_t muldiv_model(input muldiv_op_t f, input word_t a, input word_t b);
		longint sa, sb, ua, ub;
		logic [63:0] prod;
		word_t res;
		sa = longint'(signed'(a)); // Sign extended
		sb = longint'(signed'(b));
		ua = longint'(a); // Zero extended
		ub = longint'(b);
		case (f)
			OP_MUL, OP_MULH: prod = sa * sb;
			OP_MULHSU: prod = sa * ub; // Fits in 64 bits, so the top word is exact
			OP_MULHU: prod = ua * ub;
			default: prod = '0;
		endcase
		case (f)
			OP_MUL: res = prod[31:0];
			OP_MULH, OP_MULHSU, OP_MULHU: res = prod[63:32];
			OP_DIV: begin
				if (b == '0)
					res = '1; // Divide by zero
				else if (a == 32'h8000_0000 && b == '1)
					res = a; // Overflow keeps the dividend
				else
					res = word_t'(sa / sb); // Truncates toward zero
			end
			OP_DIVU: res = (b == '0) ? '1 : a / b;
			OP_REM: begin
				if (b == '0)
					res = a;
				else if (a == 32'h8000_0000 && b == '1)
					res = '0;
				else
					res = word_t'(sa % sb); // Sign follows the dividend
			end
			default: res = (b == '0) ? a : a % b; // REMU
		endcase
		return res;
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
			if (ready) begin
				$display("Error: ready pulsed while reset is asserted");
				errors <= errors + 1;
			end
		end else if (ready) begin
			if (!pending) begin
				$display("Error: ready pulsed with no operation pending");
				errors <= errors + 1;
			end else begin
				checks <= checks + 1;
				if (result !== muldiv_model(op_q, a_q, b_q)) begin
					$display("MISMATCH %s(%h, %h): expected %h, actual %h", op_q.name(), a_q, b_q,
						muldiv_model(op_q, a_q, b_q), result);
					errors <= errors + 1;
				end
			end
			pending <= 1'b0;
		end else if (valid && !pending) begin // Same edge the DUT accepts on
			op_q <= op;
			a_q <= operand_a;
			b_q <= operand_b;
			pending <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: tests/muldiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;
	import muldiv_types_pkg::*;
	import muldiv_op_pkg::*;

	localparam int N_EDGE = 7; // Corner operand values
	localparam int N_RANDOM = 300;
	localparam int N_OPS = 8 * N_EDGE * N_EDGE + N_RANDOM;
	localparam int OP_CYCLES = DIV_STEPS + 8; // Divider latency plus handshake gaps
	localparam int CYCLE_LIMIT = N_OPS * OP_CYCLES + 100;

	logic clk, rst_n, valid, ready;
	muldiv_op_t op;
	word_t operand_a, operand_b, result;
	int error_count, check_count;
	int issued;
	int cycles = 0;
	int total_errors;
	logic [31:0] lcg_state;
	word_t edge_vals [N_EDGE];

	muldiv_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.valid     (valid),
		.op        (op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ready     (ready),
		.result    (result)
	);

	muldiv_checker i_check (
		.clk         (clk),
		.rst_n       (rst_n),
		.valid       (valid),
		.op          (op),
		.operand_a   (operand_a),
		.operand_b   (operand_b),
		.ready       (ready),
		.result      (result),
		.error_count (error_count),
		.check_count (check_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Upper halves of two draws since the low LCG bits are weak
	function automatic word_t random_word();
		word_t hi, lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[31:16], lo[31:16]};
	endfunction

	// Hold the request until ready, then drop valid
	task automatic run_op(input muldiv_op_t o, input word_t a, input word_t b);
		@(negedge clk);
		valid = 1'b1;
		op = o;
		operand_a = a;
		operand_b = b;
		issued++;
		@(negedge clk);
		while (!ready)
			@(negedge clk);
		valid = 1'b0;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		lcg_state = 32'd93616;
		// Zero, one, minus one, MIN, MAX, small of both signs
		edge_vals = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000,
			32'h7FFF_FFFF, 32'h0000_0007, 32'hFFFF_FFF9};
		rst_n = 1'b0;
		valid = 1'b0;
		op = OP_MUL;
		operand_a = '0;
		operand_b = '0;
		issued = 0;
		repeat (8) @(posedge clk); // Eight rising edges under reset
		@(negedge clk);
		rst_n = 1'b1;
		repeat (5) @(negedge clk); // Checker flags any stray ready while idle

		// Every op over every corner pair covers all sign combinations
		for (int o = 0; o < 8; o++)
			for (int i = 0; i < N_EDGE; i++)
				for (int j = 0; j < N_EDGE; j++)
					run_op(muldiv_op_t'(o), edge_vals[i], edge_vals[j]);

		for (int n = 0; n < N_RANDOM; n++) begin
			word_t r, a, b;
			r = lcg_next();
			a = random_word();
			b = random_word();
			if (r[25:24] == 2'b00)
				b = b >> 28; // Small divisors, zero now and then
			run_op(muldiv_op_t'(r[31:29]), a, b);
		end

		repeat (4) @(negedge clk); // Last compare lands
		total_errors = error_count;
		if (check_count != issued) begin
			$display("Error: %0d results checked for %0d operations", check_count, issued);
			total_errors++;
		end
		$display("Errors: %0d, checks: %0d, operations: %0d", total_errors, check_count, issued);
		if (total_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
